// ==== common/gpioPkg.sv ====
package gpioPkg;

	// Width of the GPIO port
	localparam int pinCount = 8;

	// One value per pin
	typedef logic [pinCount-1:0] pinVec;

	// Flops between the pins and the execute stage
	localparam int syncDepth = 2;

	// Execute-stage result handed to the response stage
	//   valid         an accepted command passed through execute
	//   isRead        a read op, so readData carries the value
	//   wantResponse  requester asked for an ack
	//   dest          bus tag, carried through unchanged
	//   readData      selected register or synchronized pins
	typedef struct packed {
		logic       valid;
		logic       isRead;
		logic       wantResponse;
		logic [3:0] dest;
		pinVec      readData;
	} execResult;

endpackage

// ==== common/ioBusPkg.sv ====
package ioBusPkg;

	// Data word in either direction on the bus
	typedef logic [15:0] ioWord;

	// Register tag the requester supplies and gets back
	typedef logic [3:0] destReg;

	// Low bit of the operation field in a command word
	localparam int opLsb = 10;

	// Operation encoding, bits 12:10 of the command word
	typedef enum logic [2:0] {
		opReadIn    = 3'd0,
		opReadOut   = 3'd1,
		opReadEn    = 3'd2,
		opWriteOut  = 3'd3,
		opSetOut    = 3'd4,
		opClearOut  = 3'd5,
		opToggleOut = 3'd6,
		opWriteEn   = 3'd7
	} gpioOp;

	// Command word layout
	//   15:13  ignored
	//   12:10  operation
	//   9:8    ignored
	//   7:0    operand, one bit per pin
	typedef struct packed {
		logic           valid;
		gpioOp          op;
		gpioPkg::pinVec operand;
		destReg         dest;
		logic           wantResponse;
	} decodedCmd;

	// Reply as seen on the bus
	typedef struct packed {
		logic   ack;
		logic   commandResponse;
		logic   regResponseFlag;
		destReg dest;
		ioWord  data;
	} busReply;

endpackage

// ==== gpioController/gpioCommandDecode.sv ====
`timescale 1ns/1ps

module gpioCommandDecode (
	input  logic                clk,
	input  logic                arstN,
	input  logic                clkEn,
	input  logic                req,
	input  logic                commandEn,
	input  logic                responseRequested,
	input  ioBusPkg::destReg    destRegIn,
	input  ioBusPkg::ioWord     dataIn,
	output ioBusPkg::decodedCmd cmd
);
	import ioBusPkg::*;
	import gpioPkg::*;

	// Strobe qualified by the command enable
	logic   accept;

	// Operation field pulled out of the command word
	gpioOp  opField;

	// Stage register
	logic   validQ;
	gpioOp  opQ;
	pinVec  operandQ;
	destReg destQ;
	logic   wantResponseQ;

	assign accept = req && commandEn;

	assign opField = gpioOp'(dataIn[opLsb +: $bits(gpioOp)]);

	// Stage valid bit
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else if (clkEn) begin
			validQ <= accept;
		end
	end

	// Command fields sampled on every enabled edge
	always_ff @(posedge clk) begin
		if (clkEn) begin
			opQ           <= opField;
			operandQ      <= dataIn[pinCount-1:0];
			destQ         <= destRegIn;
			wantResponseQ <= responseRequested;
		end
	end

	assign cmd = '{
		valid:        validQ,
		op:           opQ,
		operand:      operandQ,
		dest:         destQ,
		wantResponse: wantResponseQ
	};

endmodule

// ==== gpioController/gpioPortRegs.sv ====
`timescale 1ns/1ps

module gpioPortRegs (
	input  logic                clk,
	input  logic                arstN,
	input  logic                clkEn,
	input  ioBusPkg::decodedCmd cmd,
	input  gpioPkg::pinVec      gpioIn,
	output gpioPkg::pinVec      gpioOut,
	output gpioPkg::pinVec      gpioOutEn,
	output gpioPkg::execResult  result
);
	import ioBusPkg::*;
	import gpioPkg::*;

	// Port registers and their next values
	pinVec  outReg;
	pinVec  enReg;
	pinVec  outNext;
	pinVec  enNext;

	// Input synchronizer chain
	pinVec  syncQ [syncDepth];
	pinVec  pinsIn;

	// Read path
	pinVec  readValue;
	logic   isRead;

	// Result register
	logic   resValidQ;
	logic   resIsReadQ;
	logic   resWantQ;
	destReg resDestQ;
	pinVec  resDataQ;

	// Pins are sampled only on enabled edges, so a stall freezes the chain too
	always_ff @(posedge clk) begin
		if (clkEn) begin
			syncQ[0] <= gpioIn;
			for (int i = 1; i < syncDepth; i++) begin
				syncQ[i] <= syncQ[i-1];
			end
		end
	end

	assign pinsIn = syncQ[syncDepth-1];

	// Modify the output or enable register
	always_comb begin
		outNext = outReg;
		enNext  = enReg;
		if (cmd.valid) begin
			case (cmd.op)
				opWriteOut:  outNext = cmd.operand;
				opSetOut:    outNext = outReg | cmd.operand;
				opClearOut:  outNext = outReg & ~cmd.operand;
				opToggleOut: outNext = outReg ^ cmd.operand;
				opWriteEn:   enNext  = cmd.operand;
				default:     ;
			endcase
		end
	end

	// Read value comes from the registers before this edge's update
	always_comb begin
		case (cmd.op)
			opReadIn:  readValue = pinsIn;
			opReadOut: readValue = outReg;
			opReadEn:  readValue = enReg;
			default:   readValue = '0;
		endcase
	end

	assign isRead = cmd.op inside {opReadIn, opReadOut, opReadEn};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outReg    <= '0;
			enReg     <= '0;
			resValidQ <= 1'b0;
		end else if (clkEn) begin
			outReg    <= outNext;
			enReg     <= enNext;
			resValidQ <= cmd.valid;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (clkEn) begin
			resIsReadQ <= isRead;
			resWantQ   <= cmd.wantResponse;
			resDestQ   <= cmd.dest;
			resDataQ   <= readValue;
		end
	end

	assign result = '{
		valid:        resValidQ,
		isRead:       resIsReadQ,
		wantResponse: resWantQ,
		dest:         resDestQ,
		readData:     resDataQ
	};

	assign gpioOut   = outReg;
	assign gpioOutEn = enReg;

endmodule

// ==== gpioController/gpioResponse.sv ====
`timescale 1ns/1ps

module gpioResponse (
	input  logic               clk,
	input  logic               arstN,
	input  logic               clkEn,
	input  gpioPkg::execResult result,
	output ioBusPkg::busReply  reply
);
	import ioBusPkg::*;
	import gpioPkg::*;

	// Reply goes out only for accepted commands that asked for one
	logic    replyDue;
	busReply replyNext;
	busReply replyQ;

	assign replyDue = result.valid && result.wantResponse;

	always_comb begin
		replyNext = '0;
		if (replyDue) begin
			replyNext.ack  = 1'b1;
			replyNext.dest = result.dest;
			if (result.isRead) begin
				replyNext.regResponseFlag = 1'b1;
				// Zero-extend pin data to a full bus word
				replyNext.data = {{($bits(ioWord) - pinCount){1'b0}}, result.readData};
			end else begin
				replyNext.commandResponse = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			replyQ <= '0;
		end else if (clkEn) begin
			replyQ <= replyNext;
		end else begin
			// Stalled, so the handshake must not repeat
			replyQ.ack             <= 1'b0;
			replyQ.commandResponse <= 1'b0;
			replyQ.regResponseFlag <= 1'b0;
		end
	end

	assign reply = replyQ;

endmodule

// ==== gpioController/gpioController.sv ====
`timescale 1ns/1ps

module gpioController (
	input  logic             clk,
	input  logic             arstN,
	input  logic             clkEn,
	input  logic             req,
	input  logic             commandEn,
	input  logic             responseRequested,
	input  ioBusPkg::destReg destRegIn,
	input  ioBusPkg::ioWord  dataIn,
	input  gpioPkg::pinVec   gpioIn,
	output logic             ack,
	output logic             commandResponse,
	output logic             regResponseFlag,
	output ioBusPkg::destReg destRegOut,
	output ioBusPkg::ioWord  dataOut,
	output gpioPkg::pinVec   gpioOut,
	output gpioPkg::pinVec   gpioOutEn
);
	import ioBusPkg::*;
	import gpioPkg::*;

	// Stage-to-stage links
	decodedCmd cmd;
	execResult result;
	busReply   reply;

	// Stage 1
	gpioCommandDecode i_decode (
		.clk              (clk),
		.arstN            (arstN),
		.clkEn            (clkEn),
		.req              (req),
		.commandEn        (commandEn),
		.responseRequested(responseRequested),
		.destRegIn        (destRegIn),
		.dataIn           (dataIn),
		.cmd              (cmd)
	);

	// Stage 2, port state lives here
	gpioPortRegs i_portRegs (
		.clk      (clk),
		.arstN    (arstN),
		.clkEn    (clkEn),
		.cmd      (cmd),
		.gpioIn   (gpioIn),
		.gpioOut  (gpioOut),
		.gpioOutEn(gpioOutEn),
		.result   (result)
	);

	// Stage 3
	gpioResponse i_response (
		.clk   (clk),
		.arstN (arstN),
		.clkEn (clkEn),
		.result(result),
		.reply (reply)
	);

	// Bus reply onto the ports
	assign ack             = reply.ack;
	assign commandResponse = reply.commandResponse;
	assign regResponseFlag = reply.regResponseFlag;
	assign destRegOut      = reply.dest;
	assign dataOut         = reply.data;

endmodule

// ==== bench/gpioControllerTb.sv ====
`timescale 1ns/1ps

module gpioControllerTb;
	import ioBusPkg::*;
	import gpioPkg::*;

	// Words per line of the cases file and room for the table
	localparam int caseCols = 15;
	localparam int maxCases = 64;

	logic   clk;
	logic   arstN;
	logic   clkEn;
	logic   req;
	logic   commandEn;
	logic   responseRequested;
	destReg destRegIn;
	ioWord  dataIn;
	pinVec  gpioIn;
	logic   ack;
	logic   commandResponse;
	logic   regResponseFlag;
	destReg destRegOut;
	ioWord  dataOut;
	pinVec  gpioOut;
	pinVec  gpioOutEn;

	logic [15:0] caseMem [caseCols*maxCases];

	int caseCount;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	int testErrors;
	int testsRun;
	int testsFailed;

	gpioController i_dut (
		.clk              (clk),
		.arstN            (arstN),
		.clkEn            (clkEn),
		.req              (req),
		.commandEn        (commandEn),
		.responseRequested(responseRequested),
		.destRegIn        (destRegIn),
		.dataIn           (dataIn),
		.gpioIn           (gpioIn),
		.ack              (ack),
		.commandResponse  (commandResponse),
		.regResponseFlag  (regResponseFlag),
		.destRegOut       (destRegOut),
		.dataOut          (dataOut),
		.gpioOut          (gpioOut),
		.gpioOutEn        (gpioOutEn)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog, armed once the cases are loaded
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	// Lines end at the first empty or zero test number
	function automatic int countCases();
		int n;
		n = 0;
		while (n < maxCases && !$isunknown(caseMem[n*caseCols]) && caseMem[n*caseCols] != 0) begin
			n++;
		end
		return n;
	endfunction

	task automatic applyCase(input int k);
		int          base;
		logic [31:0] randWord;
		base     = k * caseCols;
		randWord = $urandom();
		clkEn             = caseMem[base+1][0];
		req               = caseMem[base+2][0];
		commandEn         = caseMem[base+3][0];
		responseRequested = caseMem[base+4][0];
		destRegIn         = caseMem[base+5][3:0];
		// Top three bits are ignored by the decoder
		dataIn            = {randWord[2:0], caseMem[base+6][12:0]};
		gpioIn            = caseMem[base+7][7:0];
	endtask

	task automatic compareField(input int k, input string name,
			input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED case %0d %s: expected %h, got %h", k + 1, name,
				expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkCase(input int k);
		int      base;
		busReply expReply;
		pinVec   expOut;
		pinVec   expEn;
		base = k * caseCols;
		expReply.ack             = caseMem[base+8][0];
		expReply.commandResponse = caseMem[base+9][0];
		expReply.regResponseFlag = caseMem[base+10][0];
		expReply.dest            = caseMem[base+11][3:0];
		expReply.data            = caseMem[base+12];
		expOut                   = caseMem[base+13][7:0];
		expEn                    = caseMem[base+14][7:0];
		compareField(k, "ack", expReply.ack, ack);
		compareField(k, "commandResponse", expReply.commandResponse, commandResponse);
		compareField(k, "regResponseFlag", expReply.regResponseFlag, regResponseFlag);
		compareField(k, "destRegOut", expReply.dest, destRegOut);
		compareField(k, "dataOut", expReply.data, dataOut);
		compareField(k, "gpioOut", expOut, gpioOut);
		compareField(k, "gpioOutEn", expEn, gpioOutEn);
	endtask

	task automatic finishTest(input int testId);
		testsRun++;
		if (testErrors == 0) begin
			$display("Test %0d passed", testId);
		end else begin
			testsFailed++;
			$display("Test %0d failed with %0d mismatches", testId, testErrors);
		end
		testErrors = 0;
	endtask

	initial begin
		void'($urandom(18));
		arstN             = 1'b0;
		clkEn             = 1'b0;
		req               = 1'b0;
		commandEn         = 1'b0;
		responseRequested = 1'b0;
		destRegIn         = '0;
		dataIn            = '0;
		gpioIn            = '0;
		$readmemh("bench/gpioCases.txt", caseMem);
		caseCount  = countCases();
		cycleLimit = caseCount + 20;
		if (caseCount == 0) begin
			$display("No cases could be loaded from bench/gpioCases.txt");
			errorCount++;
		end

		repeat (5) @(posedge clk);
		#2 arstN = 1'b1;

		// Drive shortly after the edge, check just before the next one
		for (int k = 0; k < caseCount; k++) begin
			@(posedge clk);
			#2;
			applyCase(k);
			#16;
			checkCase(k);
			if (k == caseCount - 1 || caseMem[(k+1)*caseCols] != caseMem[k*caseCols]) begin
				finishTest(caseMem[k*caseCols]);
			end
		end

		$display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== bench/gpioCases.txt ====
// Stimulus: test clkEn req commandEn responseRequested destRegIn dataIn gpioIn
// Expected: ack commandResponse regResponseFlag destRegOut dataOut gpioOut gpioOutEn
1 1 0 0 0 0 0000 00   0 0 0 0 0000 00 00
1 1 0 0 0 0 0000 00   0 0 0 0 0000 00 00
1 1 0 0 0 0 0000 00   0 0 0 0 0000 00 00
2 1 1 1 1 1 0CA5 00   0 0 0 0 0000 00 00
2 1 1 1 1 2 100F 00   0 0 0 0 0000 00 00
2 1 1 1 1 3 1481 00   0 0 0 0 0000 A5 00
2 1 1 1 1 4 18FF 00   1 1 0 1 0000 AF 00
2 1 1 1 1 5 0400 00   1 1 0 2 0000 2E 00
2 1 0 0 0 0 0000 00   1 1 0 3 0000 D1 00
2 1 0 0 0 0 0000 00   1 1 0 4 0000 D1 00
2 1 0 0 0 0 0000 00   1 0 1 5 00D1 D1 00
3 1 1 1 1 6 1CF0 3C   0 0 0 0 0000 D1 00
3 1 0 0 0 0 0000 3C   0 0 0 0 0000 D1 00
3 1 0 0 0 0 0000 3C   0 0 0 0 0000 D1 F0
3 1 1 1 1 7 0000 3C   1 1 0 6 0000 D1 F0
3 1 1 1 1 8 0800 3C   0 0 0 0 0000 D1 F0
3 1 0 0 0 0 0000 3C   0 0 0 0 0000 D1 F0
3 1 0 0 0 0 0000 3C   1 0 1 7 003C D1 F0
3 1 0 0 0 0 0000 3C   1 0 1 8 00F0 D1 F0
4 1 1 1 1 9 0C33 3C   0 0 0 0 0000 D1 F0
4 1 1 1 0 A 1040 3C   0 0 0 0 0000 D1 F0
4 1 1 1 0 B 1803 3C   0 0 0 0 0000 33 F0
4 1 1 1 1 C 1410 3C   1 1 0 9 0000 73 F0
4 1 0 0 0 0 0000 3C   0 0 0 0 0000 70 F0
4 1 0 0 0 0 0000 3C   0 0 0 0 0000 60 F0
4 1 0 0 0 0 0000 3C   1 1 0 C 0000 60 F0
5 1 1 0 1 D 0CFF 3C   0 0 0 0 0000 60 F0
5 1 0 1 1 E 0CFF 3C   0 0 0 0 0000 60 F0
5 1 0 0 0 0 0000 3C   0 0 0 0 0000 60 F0
5 1 0 0 0 0 0000 3C   0 0 0 0 0000 60 F0
6 1 1 1 1 1 0C0F 3C   0 0 0 0 0000 60 F0
6 1 1 1 1 2 10F0 3C   0 0 0 0 0000 60 F0
6 1 1 1 1 3 0400 3C   0 0 0 0 0000 0F F0
6 0 0 0 0 0 0000 3C   1 1 0 1 0000 FF F0
6 0 1 1 1 F 0C00 3C   0 0 0 1 0000 FF F0
6 0 0 0 0 0 0000 3C   0 0 0 1 0000 FF F0
6 1 0 0 0 0 0000 3C   0 0 0 1 0000 FF F0
6 1 0 0 0 0 0000 3C   1 1 0 2 0000 FF F0
6 1 0 0 0 0 0000 3C   1 0 1 3 00FF FF F0
6 1 0 0 0 0 0000 3C   0 0 0 0 0000 FF F0

// ==== compile.f ====
common/gpioPkg.sv
common/ioBusPkg.sv
gpioController/gpioCommandDecode.sv
gpioController/gpioPortRegs.sv
gpioController/gpioResponse.sv
gpioController/gpioController.sv
bench/gpioControllerTb.sv

// ==== Bender.yml ====
package:
  name: gpioController

sources:
  # Packages first, the bus package uses the pin types
  - common/gpioPkg.sv
  - common/ioBusPkg.sv
  # Pipeline stages and top level
  - gpioController/gpioCommandDecode.sv
  - gpioController/gpioPortRegs.sv
  - gpioController/gpioResponse.sv
  - gpioController/gpioController.sv
  # Testbench
  - target: test
    files:
      - bench/gpioControllerTb.sv

# Cases file read at run time from the project root
# bench/gpioCases.txt
